//--- run.sh
#!/bin/sh
# Compile and run the 10GBASE-R receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_xg_rx -Mdir obj_dir -f tb.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

out=$(./obj_dir/Vtb_xg_rx +verilator+error+limit+1000)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
	echo "Simulation exited with status $rc"
	exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- source/mac_rx_framer.sv
module mac_rx_framer (
	input logic rx_clk,
	input logic rst_n,
	input xg_rx_pkg::xgmii_word xgmii,
	input logic xgmii_valid,
	input logic block_lock,
	output xg_rx_pkg::rx_beat beat,
	output logic beat_valid,
	output logic frame_good
);
	import xg_rx_pkg::*;

	framer_state state;
	logic [31:0] crc;
	logic [31:0] crc_next;
	logic has_ctl;
	logic err_any;
	logic [2:0] term_lane;
	logic term_ok;
	logic is_sof;
	logic is_idle_word;
	logic abort;
	logic take;

	////////////////////////////////////////////////////////////
	// CRC-32 shifted LSB first

	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c ^ {24'h0, d};
		for (int k = 0; k < 8; k++) begin
			r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
		end
		return r;
	endfunction

	// Fold the first n lanes of a word starting at lane 0
	function automatic logic [31:0] crc_bytes(
		input logic [31:0] c,
		input logic [63:0] d,
		input logic [3:0] n
	);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			if (i < n) begin
				r = crc_byte(r, d[8*i +: 8]);
			end
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Word classification

	always_comb begin
		has_ctl = |xgmii.ctl;
		err_any = 1'b0;
		term_lane = 3'd0;
		// Walk down so the lowest control lane wins
		for (int i = 7; i >= 0; i--) begin
			if (xgmii.ctl[i]) begin
				term_lane = 3'(i);
			end
			if (xgmii.ctl[i] && xgmii.data[8*i +: 8] == XGMII_ERROR) begin
				err_any = 1'b1;
			end
		end
	end

	// First control lane must be the terminate
	assign term_ok = xgmii.data[8*term_lane +: 8] == XGMII_TERM;

	// Start then six preamble bytes and the SFD in lane 7
	assign is_sof = (xgmii.ctl == 8'h01) &&
		(xgmii.data == {SFD_BYTE, {6{PREAMBLE_BYTE}}, XGMII_START});

	assign is_idle_word = (xgmii.ctl == 8'hFF) && (xgmii.data == {8{XGMII_IDLE}});

	// Lock loss aborts even without a word
	assign abort = (state == IN_FRAME) &&
		(!block_lock || (xgmii_valid && (err_any || (has_ctl && !term_ok))));
	assign take = (state == IN_FRAME) && xgmii_valid && !abort;

	// Data words fold all lanes and a terminate only those before it
	assign crc_next = crc_bytes(crc, xgmii.data, has_ctl ? {1'b0, term_lane} : 4'd8);

	////////////////////////////////////////////////////////////
	// Framer FSM

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			crc <= CRC_INIT;
			beat_valid <= 1'b0;
			frame_good <= 1'b0;
		end else begin
			beat_valid <= abort || take;
			case (state)
				IDLE: begin
					if (xgmii_valid && block_lock && is_sof) begin
						state <= IN_FRAME;
						crc <= CRC_INIT;
					end
				end
				IN_FRAME: begin
					if (abort) begin
						frame_good <= 1'b0;
						state <= DROP;
					end else if (take) begin
						crc <= crc_next;
						// Register holds the residue after a correct FCS
						frame_good <= has_ctl && (crc_next == CRC_RESIDUE);
						if (has_ctl) begin
							state <= IDLE;
						end
					end
				end
				DROP: begin
					// Hold off until the line goes idle
					if (xgmii_valid && is_idle_word) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Beat payload
	always_ff @(posedge rx_clk) begin
		if (abort || take) begin
			beat.data <= xgmii.data;
		end
		if (abort) begin
			beat.keep <= 8'h00;
			beat.last <= 1'b1;
		end else if (take) begin
			beat.keep <= has_ctl ? ~(8'hFF << term_lane) : 8'hFF;
			beat.last <= has_ctl;
		end
	end

endmodule

//--- source/pcs_block_decoder.sv
module pcs_block_decoder (
	input logic rx_clk,
	input logic rst_n,
	input xg_rx_pkg::pcs_block rx_block,
	input logic rx_block_valid,
	output xg_rx_pkg::xgmii_word xgmii,
	output logic xgmii_valid,
	output logic block_lock
);
	import xg_rx_pkg::*;

	logic hdr_ok;
	logic [LOCK_GOOD_W-1:0] good_cnt;
	logic [LOCK_BAD_W-1:0] bad_cnt;
	xgmii_word dec_word;

	////////////////////////////////////////////////////////////
	// Block to XGMII translation

	function automatic xgmii_word decode_block(input pcs_block blk);
		xgmii_word w;
		logic [63:0] tail;
		logic [3:0] n_data;
		// Anything unrecognised stays as error lanes
		w = XGMII_ERR_WORD;
		// Data bytes of a terminate block start after the type byte
		tail = blk.payload >> 8;
		n_data = 4'd8;
		if (blk.sync == SYNC_DATA) begin
			w.data = blk.payload;
			w.ctl = 8'h00;
		end else if (blk.sync == SYNC_CTRL) begin
			case (block_type'(blk.payload[7:0]))
				BT_IDLE: begin
					w.data = {8{XGMII_IDLE}};
				end
				BT_START0: begin
					// Start in lane 0, then seven payload bytes
					w.data = {blk.payload[63:8], XGMII_START};
					w.ctl = 8'h01;
				end
				BT_TERM0: n_data = 4'd0;
				BT_TERM1: n_data = 4'd1;
				BT_TERM2: n_data = 4'd2;
				BT_TERM3: n_data = 4'd3;
				BT_TERM4: n_data = 4'd4;
				BT_TERM5: n_data = 4'd5;
				BT_TERM6: n_data = 4'd6;
				BT_TERM7: n_data = 4'd7;
				default: ;
			endcase
			// Terminate: data lanes, terminate, idle fill
			if (n_data != 4'd8) begin
				for (int i = 0; i < 8; i++) begin
					if (i < n_data) begin
						w.data[8*i +: 8] = tail[8*i +: 8];
						w.ctl[i] = 1'b0;
					end else if (i == n_data) begin
						w.data[8*i +: 8] = XGMII_TERM;
						w.ctl[i] = 1'b1;
					end else begin
						w.data[8*i +: 8] = XGMII_IDLE;
						w.ctl[i] = 1'b1;
					end
				end
			end
		end
		return w;
	endfunction

	// Exactly one of the two header bits set
	assign hdr_ok = rx_block.sync[1] ^ rx_block.sync[0];
	assign dec_word = decode_block(rx_block);

	////////////////////////////////////////////////////////////
	// Lock state machine

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			good_cnt <= '0;
			bad_cnt <= '0;
			block_lock <= 1'b0;
		end else if (rx_block_valid) begin
			if (hdr_ok) begin
				bad_cnt <= '0;
				// Only counted while hunting for lock
				if (!block_lock) begin
					if (good_cnt == LOCK_GOOD_W'(LOCK_GOOD_COUNT - 1)) begin
						block_lock <= 1'b1;
						good_cnt <= '0;
					end else begin
						good_cnt <= good_cnt + 1'b1;
					end
				end
			end else begin
				good_cnt <= '0;
				if (block_lock) begin
					if (bad_cnt == LOCK_BAD_W'(LOCK_BAD_COUNT - 1)) begin
						block_lock <= 1'b0;
						bad_cnt <= '0;
					end else begin
						bad_cnt <= bad_cnt + 1'b1;
					end
				end
			end
		end
	end

	// Output word, one cycle behind the block
	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			xgmii_valid <= 1'b0;
		end else begin
			xgmii_valid <= rx_block_valid;
		end
	end

	always_ff @(posedge rx_clk) begin
		if (rx_block_valid) begin
			// Unlocked alignment is not trusted
			xgmii <= block_lock ? dec_word : XGMII_ERR_WORD;
		end
	end

endmodule

//--- source/rx_frame_buffer.sv
module rx_frame_buffer (
	input logic rx_clk,
	input logic rst_n,
	input xg_rx_pkg::rx_beat beat,
	input logic beat_valid,
	input logic frame_good,
	output xg_rx_pkg::rx_beat m_beat,
	output logic m_valid,
	input logic m_ready,
	output logic [xg_rx_pkg::COUNT_WIDTH-1:0] frames_ok,
	output logic [xg_rx_pkg::COUNT_WIDTH-1:0] frames_dropped
);
	import xg_rx_pkg::*;

	rx_beat mem [BUF_DEPTH];

	// One extra bit tells full from empty
	logic [BUF_AW:0] wr_ptr;
	logic [BUF_AW:0] cm_ptr;
	logic [BUF_AW:0] rd_ptr;
	logic [BUF_AW:0] occupancy;
	logic [BUF_AW-1:0] wr_idx;
	logic [BUF_AW-1:0] prev_idx;
	logic full;
	logic ovf;
	logic has_data;
	logic fits;
	logic write_en;
	logic commit;
	logic mark_prev;

	////////////////////////////////////////////////////////////
	// Write side decisions

	assign occupancy = wr_ptr - rd_ptr;
	assign full = occupancy == (BUF_AW + 1)'(BUF_DEPTH);
	assign wr_idx = wr_ptr[BUF_AW-1:0];
	assign prev_idx = wr_idx - 1'b1;
	assign has_data = |beat.keep;

	// Once a beat is lost the rest of the frame is not stored
	assign fits = !full && !ovf;

	// Bad last beats are never stored
	assign write_en = beat_valid && has_data && fits && (!beat.last || frame_good);

	// Empty tail needs an earlier beat to carry last
	assign commit = beat_valid && beat.last && frame_good && !ovf &&
		(has_data ? !full : (wr_ptr != cm_ptr));
	assign mark_prev = commit && !has_data;

	always_ff @(posedge rx_clk) begin
		if (write_en) begin
			mem[wr_idx] <= beat;
		end
		if (mark_prev) begin
			mem[prev_idx].last <= 1'b1;
		end
	end

	// Pointers and frame accounting
	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			cm_ptr <= '0;
			rd_ptr <= '0;
			ovf <= 1'b0;
			frames_ok <= '0;
			frames_dropped <= '0;
		end else begin
			if (beat_valid) begin
				if (!beat.last) begin
					if (fits) begin
						wr_ptr <= wr_ptr + 1'b1;
					end else begin
						ovf <= 1'b1;
					end
				end else begin
					ovf <= 1'b0;
					if (commit) begin
						frames_ok <= frames_ok + 1'b1;
						if (has_data) begin
							wr_ptr <= wr_ptr + 1'b1;
							cm_ptr <= wr_ptr + 1'b1;
						end else begin
							cm_ptr <= wr_ptr;
						end
					end else begin
						// Rewind over the partial frame
						wr_ptr <= cm_ptr;
						frames_dropped <= frames_dropped + 1'b1;
					end
				end
			end
			if (m_valid && m_ready) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read side

	// Only committed entries are visible, so the head entry never changes
	assign m_valid = rd_ptr != cm_ptr;
	assign m_beat = mem[rd_ptr[BUF_AW-1:0]];

endmodule

//--- source/xg_rx_pkg.sv
package xg_rx_pkg;

	////////////////////////////////////////////////////////////
	// Block lock thresholds

	// Consecutive good sync headers to gain lock
	localparam int LOCK_GOOD_COUNT = 16;
	localparam int LOCK_GOOD_W = $clog2(LOCK_GOOD_COUNT);

	// Consecutive bad sync headers to lose lock
	localparam int LOCK_BAD_COUNT = 4;
	localparam int LOCK_BAD_W = $clog2(LOCK_BAD_COUNT);

	// Sync header values, the other two are invalid
	localparam logic [1:0] SYNC_DATA = 2'b01;
	localparam logic [1:0] SYNC_CTRL = 2'b10;

	////////////////////////////////////////////////////////////
	// XGMII characters

	localparam logic [7:0] XGMII_IDLE = 8'h07;
	localparam logic [7:0] XGMII_START = 8'hFB;
	localparam logic [7:0] XGMII_TERM = 8'hFD;
	localparam logic [7:0] XGMII_ERROR = 8'hFE;
	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hD5;

	////////////////////////////////////////////////////////////
	// Frame buffer and CRC

	// Buffer capacity in beats
	localparam int BUF_DEPTH = 64;
	localparam int BUF_AW = $clog2(BUF_DEPTH);
	localparam int COUNT_WIDTH = 16;

	// Reflected CRC-32, no final inversion in the register
	localparam logic [31:0] CRC_POLY = 32'hEDB88320;
	localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;
	localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

	// One 66-bit block, payload bit 0 first on the wire
	typedef struct packed {
		logic [1:0] sync;
		logic [63:0] payload;
	} pcs_block;

	// Lane i is data[8*i +: 8] and ctl[i], lane 0 first on the wire
	typedef struct packed {
		logic [63:0] data;
		logic [7:0] ctl;
	} xgmii_word;

	// Packed frame bytes, keep is contiguous from lane 0
	typedef struct packed {
		logic [63:0] data;
		logic [7:0] keep;
		logic last;
	} rx_beat;

	// Control block type byte, TERMn has n data bytes first
	typedef enum logic [7:0] {
		BT_IDLE = 8'h1E,
		BT_START0 = 8'h78,
		BT_TERM0 = 8'h87,
		BT_TERM1 = 8'h99,
		BT_TERM2 = 8'hAA,
		BT_TERM3 = 8'hB4,
		BT_TERM4 = 8'hCC,
		BT_TERM5 = 8'hD2,
		BT_TERM6 = 8'hE1,
		BT_TERM7 = 8'hFF
	} block_type;

	typedef enum logic [1:0] {
		IDLE,
		IN_FRAME,
		DROP
	} framer_state;

	// All eight lanes carrying the error character
	localparam xgmii_word XGMII_ERR_WORD = '{data: {8{XGMII_ERROR}}, ctl: 8'hFF};

endpackage

//--- source/xg_rx_top.sv
module xg_rx_top (
	input logic rx_clk,
	input logic rst_n,
	input xg_rx_pkg::pcs_block rx_block,
	input logic rx_block_valid,
	output xg_rx_pkg::rx_beat m_beat,
	output logic m_valid,
	input logic m_ready,
	output logic block_lock,
	output logic [xg_rx_pkg::COUNT_WIDTH-1:0] frames_ok,
	output logic [xg_rx_pkg::COUNT_WIDTH-1:0] frames_dropped
);
	import xg_rx_pkg::*;

	// Decoder to framer
	xgmii_word xgmii;
	logic xgmii_valid;

	// Framer to buffer
	rx_beat beat;
	logic beat_valid;
	logic frame_good;

	////////////////////////////////////////////////////////////
	// PCS decode

	pcs_block_decoder decode (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.rx_block(rx_block),
		.rx_block_valid(rx_block_valid),
		.xgmii(xgmii),
		.xgmii_valid(xgmii_valid),
		.block_lock(block_lock)
	);

	////////////////////////////////////////////////////////////
	// MAC framing and FCS check

	mac_rx_framer execute (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.xgmii(xgmii),
		.xgmii_valid(xgmii_valid),
		.block_lock(block_lock),
		.beat(beat),
		.beat_valid(beat_valid),
		.frame_good(frame_good)
	);

	////////////////////////////////////////////////////////////
	// Store and forward

	rx_frame_buffer result (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.beat(beat),
		.beat_valid(beat_valid),
		.frame_good(frame_good),
		.m_beat(m_beat),
		.m_valid(m_valid),
		.m_ready(m_ready),
		.frames_ok(frames_ok),
		.frames_dropped(frames_dropped)
	);

endmodule

//--- tb.f
source/xg_rx_pkg.sv
source/pcs_block_decoder.sv
source/mac_rx_framer.sv
source/rx_frame_buffer.sv
source/xg_rx_top.sv
verification/xg_rx_chk.sv
verification/xg_rx_monitor.sv
verification/tb_xg_rx.sv

//--- verification/tb_xg_rx.sv
module tb_xg_rx;
	import xg_rx_pkg::*;

	logic rx_clk;
	logic rst_n;
	pcs_block rx_block;
	logic rx_block_valid;
	rx_beat m_beat;
	logic m_valid;
	logic m_ready;
	logic block_lock;
	logic [COUNT_WIDTH-1:0] frames_ok;
	logic [COUNT_WIDTH-1:0] frames_dropped;

	// Block type codes of TERM0 to TERM7
	localparam logic [7:0] TERM_CODE [8] = '{8'h87, 8'h99, 8'hAA, 8'hB4,
		8'hCC, 8'hD2, 8'hE1, 8'hFF};
	localparam logic [63:0] IDLE_PAYLOAD = 64'h1E;

	integer seed = 87;
	// 0 low, 1 high, 2 random
	int ready_mode;
	bit gap_mode;
	int test_errors;
	int ok_base;
	int drop_base;
	logic [7:0] frame[$];

	xg_rx_top dut_i (.*);

	xg_rx_monitor mon_i (
		.rx_clk(rx_clk),
		.rst_n(rst_n),
		.m_beat(m_beat),
		.m_valid(m_valid),
		.m_ready(m_ready)
	);

	initial begin
		rx_clk = 1'b0;
		forever begin
			#20 rx_clk = ~rx_clk;
		end
	end

	////////////////////////////////////////////////////////////
	// Drivers

	task automatic tick(input logic [1:0] sync, input logic [63:0] payload, input logic valid);
		int r;
		@(negedge rx_clk);
		r = $random(seed);
		rx_block.sync = sync;
		rx_block.payload = payload;
		rx_block_valid = valid;
		m_ready = (ready_mode == 2) ? r[0] : (ready_mode == 1);
	endtask

	// Sometimes a dead cycle first
	task automatic send_block(input logic [1:0] sync, input logic [63:0] payload);
		int r;
		r = $random(seed);
		if (gap_mode && r[1:0] == 2'b00) begin
			tick(sync, payload, 1'b0);
		end
		tick(sync, payload, 1'b1);
	endtask

	task automatic send_idle(input int n);
		repeat (n) begin
			send_block(2'b10, IDLE_PAYLOAD);
		end
	endtask

	// Start, data blocks, TERMn; data block bad_at gets a bad header
	task automatic send_frame(input logic [7:0] bytes[$], input int bad_at);
		logic [63:0] p;
		int full;
		full = bytes.size() / 8;
		send_block(2'b10, {8'hD5, {6{8'h55}}, 8'h78});
		for (int i = 0; i < full; i++) begin
			for (int k = 0; k < 8; k++) begin
				p[8*k +: 8] = bytes[8*i + k];
			end
			send_block((i == bad_at) ? 2'b00 : 2'b01, p);
		end
		p = '0;
		for (int k = 0; k < bytes.size() % 8; k++) begin
			p[8*(k+1) +: 8] = bytes[8*full + k];
		end
		p[7:0] = TERM_CODE[bytes.size() % 8];
		send_block(2'b10, p);
	endtask

	// Random payload, then the FCS low byte first
	task automatic make_frame(input int len);
		logic [31:0] fcs;
		int r;
		frame.delete();
		for (int i = 0; i < len - 4; i++) begin
			r = $random(seed);
			frame.push_back(r[7:0]);
		end
		fcs = mon_i.frame_fcs(frame);
		for (int i = 0; i < 4; i++) begin
			frame.push_back(fcs[8*i +: 8]);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Waits and reporting

	task automatic timeout(input string what);
		$display("Timeout: %s", what);
		$display("STATUS: FAIL");
		$finish;
	endtask

	// Lock is seen one block late, so n - 1 blocks did it
	task automatic blocks_to_lock(input logic [1:0] sync, input logic level, output int n);
		n = 0;
		while (block_lock != level) begin
			send_block(sync, IDLE_PAYLOAD);
			n++;
			if (n > 100) begin
				timeout(level ? "block_lock never rose" : "block_lock never fell");
			end
		end
	endtask

	task automatic wait_drain(input string what);
		int t;
		t = 0;
		while (mon_i.pending() != 0) begin
			send_idle(1);
			t++;
			if (t > 3000) begin
				timeout(what);
			end
		end
		send_idle(4);
	endtask

	task automatic wait_counted(input int n);
		int t;
		t = 0;
		while ((frames_ok - ok_base) + (frames_dropped - drop_base) < n) begin
			send_idle(1);
			t++;
			if (t > 500) begin
				timeout("frame counters did not reach the number of frames sent");
			end
		end
	endtask

	task automatic end_test(input string name);
		$display("Test %s finished with %0d errors", name, mon_i.errors - test_errors);
		test_errors = mon_i.errors;
		ok_base = frames_ok;
		drop_base = frames_dropped;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int n;
		int r;
		int len;
		int fill;
		int exp_drop;
		rst_n = 1'b0;
		rx_block = '0;
		rx_block_valid = 1'b0;
		m_ready = 1'b0;
		ready_mode = 1;
		gap_mode = 1'b0;
		test_errors = 0;
		ok_base = 0;
		drop_base = 0;
		repeat (10) @(negedge rx_clk);
		rst_n = 1'b1;

		// Lock gain, loss, then a frame sent while unlocked
		blocks_to_lock(2'b10, 1'b1, n);
		mon_i.check_value("blocks to gain lock", n - 1, LOCK_GOOD_COUNT);
		blocks_to_lock(2'b00, 1'b0, n);
		mon_i.check_value("blocks to lose lock", n - 1, LOCK_BAD_COUNT);
		make_frame(64);
		mon_i.expect_frame(frame, 1'b0);
		send_frame(frame, -1);
		blocks_to_lock(2'b10, 1'b1, n);
		send_idle(8);
		mon_i.check_value("frames_ok after unlocked frame", frames_ok, 0);
		mon_i.check_value("frames_dropped after unlocked frame", frames_dropped, 0);
		end_test("lock");

		// Every TERMn case
		for (int k = 0; k < 8; k++) begin
			r = $random(seed);
			len = 64 + 8 * (r[7:0] % 17) + k;
			make_frame(len);
			mon_i.expect_frame(frame, 1'b1);
			send_frame(frame, -1);
			send_idle(2);
		end
		wait_drain("good frames were not all delivered");
		mon_i.check_value("frames_ok after good frames", frames_ok - ok_base, 8);
		end_test("good_frames");

		// Bad FCS, error block, then a good frame
		make_frame(90);
		frame[frame.size() - 2] ^= 8'h40;
		mon_i.expect_frame(frame, 1'b0);
		send_frame(frame, -1);
		send_idle(3);
		make_frame(120);
		mon_i.expect_frame(frame, 1'b0);
		send_frame(frame, 5);
		send_idle(3);
		make_frame(75);
		mon_i.expect_frame(frame, 1'b1);
		send_frame(frame, -1);
		wait_drain("good frame after bad frames was not delivered");
		mon_i.check_value("frames_dropped after bad frames", frames_dropped - drop_base, 2);
		mon_i.check_value("frames_ok after bad frames", frames_ok - ok_base, 1);
		end_test("bad_frames");

		// Random m_ready and dead cycles on the input
		ready_mode = 2;
		gap_mode = 1'b1;
		for (int k = 0; k < 10; k++) begin
			r = $random(seed);
			len = 64 + (r[7:0] % 137);
			make_frame(len);
			mon_i.expect_frame(frame, 1'b1);
			send_frame(frame, -1);
			send_idle((len + 7) / 8 + 4 + r[10:8]);
		end
		wait_drain("frames under random m_ready were not all delivered");
		mon_i.check_value("frames_ok under random m_ready", frames_ok - ok_base, 10);
		end_test("random_ready");

		// Stalled output until the buffer overflows
		ready_mode = 0;
		gap_mode = 1'b0;
		fill = 0;
		exp_drop = 0;
		for (int k = 0; k < 6; k++) begin
			r = $random(seed);
			len = 97 + r[2:0];
			make_frame(len);
			if (exp_drop > 0 || fill + (len + 7) / 8 > BUF_DEPTH) begin
				exp_drop++;
			end else begin
				fill += (len + 7) / 8;
			end
			mon_i.expect_frame(frame, exp_drop == 0);
			send_frame(frame, -1);
			send_idle(2);
		end
		wait_counted(6);
		mon_i.check_value("frames_dropped on overflow", frames_dropped - drop_base, exp_drop);
		ready_mode = 1;
		wait_drain("frames held during the stall were not delivered");
		mon_i.check_value("frames_ok on overflow", frames_ok - ok_base, 6 - exp_drop);
		end_test("overflow");

		n = mon_i.errors + dut_i.result.chk_i.fails;
		$display("Summary: 5 tests, %0d frames expected, %0d beats checked, %0d errors",
			mon_i.frames_expected, mon_i.beats_checked, n);
		if (n == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- verification/xg_rx_chk.sv
module xg_rx_chk (
	input logic rx_clk,
	input logic rst_n,
	input xg_rx_pkg::rx_beat m_beat,
	input logic m_valid,
	input logic m_ready,
	input logic [xg_rx_pkg::BUF_AW:0] occupancy
);
	import xg_rx_pkg::*;

	// Count of failed assertions
	int fails = 0;

	// No output while held in reset
	reset_quiet: assert property (@(posedge rx_clk) !rst_n |-> !m_valid)
		else begin
			$error("m_valid is high during reset");
			fails++;
		end

	// A stalled beat stays put until it transfers
	stall_hold: assert property (@(posedge rx_clk) disable iff (!rst_n)
		(m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
		else begin
			$error("m_valid or m_beat changed while m_ready was low");
			fails++;
		end

	// Never more entries than the RAM holds
	depth_limit: assert property (@(posedge rx_clk) disable iff (!rst_n)
		occupancy <= (BUF_AW + 1)'(BUF_DEPTH))
		else begin
			$error("buffer occupancy above BUF_DEPTH");
			fails++;
		end

endmodule

bind rx_frame_buffer xg_rx_chk chk_i (
	.rx_clk(rx_clk),
	.rst_n(rst_n),
	.m_beat(m_beat),
	.m_valid(m_valid),
	.m_ready(m_ready),
	.occupancy(occupancy)
);

//--- verification/xg_rx_monitor.sv
module xg_rx_monitor (
	input logic rx_clk,
	input logic rst_n,
	input xg_rx_pkg::rx_beat m_beat,
	input logic m_valid,
	input logic m_ready
);
	import xg_rx_pkg::*;

	// Beats still owed by the DUT, oldest first
	rx_beat exp_q[$];
	int errors = 0;
	int beats_checked = 0;
	int frames_expected = 0;

	////////////////////////////////////////////////////////////
	// Reference model

	// Ethernet FCS, reflected CRC-32 complemented at the end
	function automatic logic [31:0] frame_fcs(input logic [7:0] bytes[$]);
		logic [31:0] c;
		c = 32'hFFFFFFFF;
		foreach (bytes[i]) begin
			c = c ^ {24'h0, bytes[i]};
			repeat (8) begin
				c = (c >> 1) ^ (c[0] ? 32'hEDB88320 : 32'h0);
			end
		end
		return ~c;
	endfunction

	// Up to eight bytes from index first, keep grows from lane 0
	function automatic rx_beat pack_beat(input logic [7:0] bytes[$], input int first);
		rx_beat b;
		b = '0;
		for (int k = 0; k < 8; k++) begin
			if (first + k < bytes.size()) begin
				b.data[8*k +: 8] = bytes[first + k];
				b.keep[k] = 1'b1;
			end
		end
		b.last = (first + 8 >= bytes.size());
		return b;
	endfunction

	function automatic int pending();
		return exp_q.size();
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	task automatic check_value(input string what, input int got, input int exp);
		if (got != exp) begin
			report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
		end
	endtask

	// Dropped frames leave nothing to compare
	task automatic expect_frame(input logic [7:0] bytes[$], input bit pass);
		if (pass) begin
			frames_expected++;
			for (int i = 0; i < bytes.size(); i += 8) begin
				exp_q.push_back(pack_beat(bytes, i));
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Output comparison

	always @(posedge rx_clk) begin
		rx_beat e;
		logic [63:0] mask;
		if (rst_n && m_valid && m_ready) begin
			beats_checked++;
			if (exp_q.size() == 0) begin
				report_error("beat delivered while no frame was expected");
			end else begin
				e = exp_q.pop_front();
				// Lanes outside keep carry no frame data
				for (int k = 0; k < 8; k++) begin
					mask[8*k +: 8] = {8{e.keep[k]}};
				end
				if (m_beat.keep != e.keep || m_beat.last != e.last ||
					((m_beat.data ^ e.data) & mask) != 64'h0) begin
					report_error($sformatf("beat %h keep %b last %b, expected %h keep %b last %b",
						m_beat.data, m_beat.keep, m_beat.last, e.data, e.keep, e.last));
				end
			end
		end
	end

endmodule
